//--- uart_cases.txt
# test op arg1 arg2: write addr value | read addr expected | wait bit | frame byte stop
# loop on_off | pin level; -1 draws a random byte, in read it means the last one drawn
1 pin 1
1 read 1 2
1 read 0 0
2 loop 1
2 write 1 4
2 write 0 -1
2 wait 0
2 read 1 15
2 read 0 -1
2 write 1 4
2 write 0 -1
2 wait 0
2 read 1 15
2 read 0 -1
2 write 1 4
2 write 0 -1
2 wait 0
2 read 1 15
2 read 0 -1
3 write 1 29
3 read 1 31
3 write 1 4
3 read 1 6
3 write 0 90
3 write 0 -1
3 read 1 4
3 wait 3
3 read 0 90
3 write 1 4
3 wait 3
3 read 0 -1
3 wait 0
3 read 1 15
4 write 1 4
4 loop 0
4 frame 165 0
4 read 1 22
4 read 0 -1
5 write 1 0
5 frame 60 1
5 read 1 2
5 read 0 -1
5 write 1 4
5 frame -1 1
5 read 1 14
5 read 0 -1
5 loop 1

//--- all.f
uart_pkg.sv
baud_timer.sv
uart_tx.sv
uart_rx.sv
uart_regs.sv
uart_top.sv
tb_uart.sv

//--- Makefile
VERILATOR   ?= verilator
FILELIST    ?= all.f
TOP         ?= tb_uart
OBJ_DIR     ?= obj_dir
BUILD_FLAGS ?= --binary --timing --assert -j 0
LINT_FLAGS  ?= -Wall
PASS_MSG    ?= All tests passed!

SIM := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(BUILD_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$($(SIM))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

//--- tb_uart.sv
`timescale 1ns/1ps
`default_nettype none

module tb_uart import uart_pkg::*; ();

   localparam int    POLL_LIMIT = 20 * BAUD_DIV; // Twenty bit times
   localparam string CASES_FILE = "uart_cases.txt";

   logic        clk;
   logic        arst_n;
   logic        write_en;
   logic        addr;
   bus_word_t   write_val;
   bus_word_t   read_val;
   logic        rx_pin;
   logic        tx_pin;
   logic        drv_pin;
   logic        loop_mode;

   int          case_test[$];
   string       case_op[$];
   int          case_a[$];
   int          case_b[$];
   int          ncases;
   logic        cases_loaded;
   logic [31:0] rng_state;
   uart_byte_t  last_rand;
   int          errors;
   int          tests_run;
   int          tests_failed;
   int          total_errors;

   assign rx_pin = loop_mode ? tx_pin : drv_pin; // Loopback or driven line

   uart_top UUT (
      .clk       (clk),
      .arst_n    (arst_n),
      .write_en  (write_en),
      .addr      (addr),
      .write_val (write_val),
      .read_val  (read_val),
      .rx_pin    (rx_pin),
      .tx_pin    (tx_pin)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1103515245 + 32'd12345;
   endfunction

   // Negative value draws the next random byte
   task automatic pick_byte(input int v, output uart_byte_t b);
      if (v < 0) begin
         rng_state = lcg_next(rng_state);
         last_rand = rng_state[23:16];
         b = last_rand;
      end else begin
         b = uart_byte_t'(v);
      end
   endtask

   task automatic bus_write(input logic a, input bus_word_t v);
      @(posedge clk);
      #1;
      write_en  = 1'b1;
      addr      = a;
      write_val = v;
      @(posedge clk);
      #1;
      write_en = 1'b0;
   endtask

   task automatic bus_read_check(input logic a, input bus_word_t exp);
      @(posedge clk);
      #1;
      addr = a;
      @(negedge clk);
      assert (read_val == exp) else begin
         $display("ERROR at %0t ns: read_val (addr %0d) got 0x%08h expected 0x%08h",
                  $time, a, read_val, exp);
         errors++;
      end
   endtask

   task automatic wait_status_bit(input logic [4:0] bit_num);
      int   cycles;
      logic seen;
      cycles = 0;
      seen   = 1'b0;
      @(posedge clk);
      #1;
      addr = 1'b1;
      while (!seen && cycles < POLL_LIMIT) begin
         @(negedge clk);
         seen = read_val[bit_num];
         cycles++;
      end
      assert (seen) else begin
         $display("Status bit %0d was still clear after %0d cycles at %0t ns",
                  bit_num, POLL_LIMIT, $time);
         errors++;
      end
   endtask

   task automatic pin_check(input logic exp);
      @(negedge clk);
      assert (tx_pin == exp) else begin
         $display("ERROR at %0t ns: tx_pin got %b expected %b", $time, tx_pin, exp);
         errors++;
      end
   endtask

   // Start bit, eight data bits LSB first, chosen stop bit
   task automatic drive_frame(input uart_byte_t data, input logic stop_bit);
      logic [9:0] bits;
      bits = {stop_bit, data, 1'b0};
      repeat (10) begin
         @(posedge clk);
         #1;
         drv_pin = bits[0];
         bits = bits >> 1;
         repeat (BAUD_DIV - 1) @(posedge clk);
      end
      @(posedge clk);
      #1;
      drv_pin = 1'b1;
      repeat (BAUD_DIV) @(posedge clk); // Idle gap
   endtask

   task automatic run_case(input string op, input int a, input int b);
      uart_byte_t rb;
      bus_word_t  val;
      if (op == "write") begin
         if (b < 0) begin
            pick_byte(b, rb);
            val = {24'd0, rb};
         end else begin
            val = bus_word_t'(b);
         end
         bus_write(a[0], val);
      end else if (op == "read") begin
         val = (b < 0) ? {24'd0, last_rand} : bus_word_t'(b);
         bus_read_check(a[0], val);
      end else if (op == "wait") begin
         wait_status_bit(5'(a));
      end else if (op == "frame") begin
         pick_byte(a, rb);
         drive_frame(rb, b[0]);
      end else if (op == "loop") begin
         @(posedge clk);
         #1;
         loop_mode = a[0];
      end else if (op == "pin") begin
         pin_check(a[0]);
      end else begin
         $display("Unknown operation '%s' in %s", op, CASES_FILE);
         errors++;
      end
   endtask

   task automatic load_cases();
      int    fd;
      int    n;
      int    a;
      int    b;
      string tok;
      string op;
      string rest;
      fd = $fopen(CASES_FILE, "r");
      if (fd == 0) begin
         $display("Could not open %s", CASES_FILE);
         total_errors++;
         return;
      end
      while ($fscanf(fd, "%s", tok) == 1) begin
         if (tok.getc(0) == "#") begin
            n = $fgets(rest, fd); // Skip comment line
         end else begin
            n = $fscanf(fd, "%s", op);
            a = 0;
            b = 0;
            if (op == "write" || op == "read" || op == "frame") begin
               n = $fscanf(fd, "%d %d", a, b);
            end else begin
               n = $fscanf(fd, "%d", a);
            end
            case_test.push_back(tok.atoi());
            case_op.push_back(op);
            case_a.push_back(a);
            case_b.push_back(b);
         end
      end
      $fclose(fd);
   endtask

   task automatic report_test(input int tnum);
      tests_run++;
      total_errors += errors;
      if (errors == 0) begin
         $display("Test %0d ok", tnum);
      end else begin
         tests_failed++;
         $display("Test %0d failed with %0d errors", tnum, errors);
      end
      errors = 0;
   endtask

   initial begin
      arst_n       = 1'b0;
      write_en     = 1'b0;
      addr         = 1'b0;
      write_val    = '0;
      drv_pin      = 1'b1;
      loop_mode    = 1'b1;
      cases_loaded = 1'b0;
      rng_state    = 32'd72399;
      last_rand    = '0;
      errors       = 0;
      tests_run    = 0;
      tests_failed = 0;
      total_errors = 0;
      load_cases();
      ncases       = case_op.size();
      cases_loaded = 1'b1;
      repeat (2) @(posedge clk);
      #1;
      arst_n = 1'b1;
      for (int i = 0; i < ncases; i++) begin
         if (i > 0 && case_test[i] != case_test[i - 1]) begin
            report_test(case_test[i - 1]);
         end
         run_case(case_op[i], case_a[i], case_b[i]);
      end
      if (ncases > 0) begin
         report_test(case_test[ncases - 1]);
      end
      $display("Tests run: %0d, failed: %0d, errors: %0d", tests_run, tests_failed,
               total_errors);
      if (ncases > 0 && tests_failed == 0 && total_errors == 0) begin
         $display("All tests passed!");
      end else begin
         $display("Test failures found");
      end
      $finish;
   end

   initial begin
      wait (cases_loaded === 1'b1);
      repeat (ncases * 12 * 10 * BAUD_DIV) @(posedge clk);
      $display("Watchdog expired before all cases finished");
      $display("Test failures found");
      $finish;
   end

endmodule

`default_nettype wire

//--- uart_top.sv
`timescale 1ns/1ps
`default_nettype none

module uart_top import uart_pkg::*; (
   input  logic      clk,
   input  logic      arst_n,
   input  logic      write_en,
   input  logic      addr,
   input  bus_word_t write_val,
   output bus_word_t read_val,
   input  logic      rx_pin,
   output logic      tx_pin
);

   logic       start_tx;
   uart_byte_t tx_byte;
   logic       tx_busy;
   logic       tx_done;
   logic       tx_run;
   logic       tx_bit_tick;
   logic       rx_en;
   logic       rx_run;
   logic       rx_half_tick;
   rx_event_t  rx_event;

   uart_regs regs (
      .clk       (clk),
      .arst_n    (arst_n),
      .write_en  (write_en),
      .addr      (addr),
      .write_val (write_val),
      .read_val  (read_val),
      .tx_busy   (tx_busy),
      .tx_done   (tx_done),
      .start_tx  (start_tx),
      .tx_byte   (tx_byte),
      .rx_en     (rx_en),
      .rx_event  (rx_event)
   );

   uart_tx tx (
      .clk      (clk),
      .arst_n   (arst_n),
      .start_tx (start_tx),
      .tx_byte  (tx_byte),
      .bit_tick (tx_bit_tick),
      .tx_run   (tx_run),
      .tx_pin   (tx_pin),
      .tx_busy  (tx_busy),
      .tx_done  (tx_done)
   );

   uart_rx rx (
      .clk       (clk),
      .arst_n    (arst_n),
      .rx_en     (rx_en),
      .rx_pin    (rx_pin),
      .half_tick (rx_half_tick),
      .rx_run    (rx_run),
      .rx_event  (rx_event)
   );

   baud_timer tx_timer ( // Transmit uses end of bit only
      .clk       (clk),
      .arst_n    (arst_n),
      .run       (tx_run),
      .half_tick (),
      .bit_tick  (tx_bit_tick)
   );

   baud_timer rx_timer ( // Receive samples at mid-bit
      .clk       (clk),
      .arst_n    (arst_n),
      .run       (rx_run),
      .half_tick (rx_half_tick),
      .bit_tick  ()
   );

endmodule

`default_nettype wire

//--- uart_regs.sv
`timescale 1ns/1ps
`default_nettype none

module uart_regs import uart_pkg::*; (
   input  logic       clk,
   input  logic       arst_n,
   input  logic       write_en,
   input  logic       addr,
   input  bus_word_t  write_val,
   output bus_word_t  read_val,
   input  logic       tx_busy,
   input  logic       tx_done,
   output logic       start_tx,
   output uart_byte_t tx_byte,
   output logic       rx_en,
   input  rx_event_t  rx_event
);

   uart_status_t status;
   uart_byte_t   queue_byte;
   uart_byte_t   rx_buf;
   logic         launch;

   // Queue full, no launch in flight, transmitter free or finishing
   assign launch = !status.tx_ready && !start_tx && (!tx_busy || tx_done);

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         status <= '{rx_err: 1'b0, rxc: 1'b0, rx_en: 1'b0, tx_ready: 1'b1, txc: 1'b0};
         start_tx <= 1'b0;
      end else begin
         start_tx <= launch;
         if (launch) begin
            status.tx_ready <= 1'b1; // Queue drained
         end
         if (write_en) begin
            if (addr) begin
               status.txc    <= write_val[0];
               status.rx_en  <= write_val[2];
               status.rxc    <= write_val[3];
               status.rx_err <= write_val[4];
            end else begin
               status.tx_ready <= 1'b0; // New byte queued
            end
         end
         // Events override bus writes
         if (tx_done) begin
            status.txc <= 1'b1;
         end
         if (rx_event.done) begin
            status.rxc <= 1'b1;
         end
         if (rx_event.frame_err) begin
            status.rx_err <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         rx_buf <= '0;
      end else if (rx_event.done) begin
         rx_buf <= rx_event.data; // Bad frames keep the old byte
      end
   end

   always_ff @(posedge clk) begin
      if (write_en && !addr) begin
         queue_byte <= write_val[7:0];
      end
      if (launch) begin
         tx_byte <= queue_byte;
      end
   end

   assign rx_en = status.rx_en;

   always_comb begin
      if (addr) begin
         read_val = {27'd0, status};
      end else begin
         read_val = {24'd0, rx_buf};
      end
   end

endmodule

`default_nettype wire

//--- uart_rx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_rx import uart_pkg::*; (
   input  logic      clk,
   input  logic      arst_n,
   input  logic      rx_en,
   input  logic      rx_pin,
   input  logic      half_tick,
   output logic      rx_run,
   output rx_event_t rx_event
);

   logic       rx_meta;
   logic       rx_sync;
   logic       rx_prev;
   rx_state_t  state;
   uart_byte_t shift_q;
   logic [2:0] bit_idx;
   logic       done_q;
   logic       err_q;
   logic       fall;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         rx_meta <= 1'b1; // Idle line is high
         rx_sync <= 1'b1;
         rx_prev <= 1'b1;
      end else begin
         rx_meta <= rx_pin;
         rx_sync <= rx_meta;
         rx_prev <= rx_sync;
      end
   end

   assign fall   = rx_prev && !rx_sync;
   assign rx_run = (state != RX_IDLE);

   always_ff @(posedge clk) begin
      if (state == RX_DATA && half_tick) begin
         shift_q <= {rx_sync, shift_q[7:1]}; // LSB arrives first
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state   <= RX_IDLE;
         bit_idx <= '0;
         done_q  <= 1'b0;
         err_q   <= 1'b0;
      end else begin
         done_q <= 1'b0;
         err_q  <= 1'b0;
         if (!rx_en) begin
            state <= RX_IDLE;
         end else begin
            case (state)
               RX_IDLE: begin
                  if (fall) begin
                     state <= RX_START;
                  end
               end
               RX_START: begin
                  if (half_tick) begin
                     if (rx_sync) begin
                        state <= RX_IDLE; // Line high again so only a glitch
                     end else begin
                        state   <= RX_DATA;
                        bit_idx <= '0;
                     end
                  end
               end
               RX_DATA: begin
                  if (half_tick) begin
                     bit_idx <= bit_idx + 3'd1;
                     if (bit_idx == 3'd7) begin
                        state <= RX_STOP;
                     end
                  end
               end
               RX_STOP: begin
                  if (half_tick) begin
                     done_q <= rx_sync;
                     err_q  <= !rx_sync; // Stop bit low
                     state  <= RX_IDLE;
                  end
               end
               default: state <= RX_IDLE;
            endcase
         end
      end
   end

   assign rx_event = '{data: shift_q, done: done_q, frame_err: err_q};

endmodule

`default_nettype wire

//--- uart_tx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_tx import uart_pkg::*; (
   input  logic       clk,
   input  logic       arst_n,
   input  logic       start_tx,
   input  uart_byte_t tx_byte,
   input  logic       bit_tick,
   output logic       tx_run,
   output logic       tx_pin,
   output logic       tx_busy,
   output logic       tx_done
);

   tx_state_t  state;
   uart_byte_t byte_q;
   logic [2:0] bit_idx;

   assign tx_busy = (state != TX_IDLE);
   assign tx_run  = tx_busy;
   assign tx_done = (state == TX_STOP) && bit_tick; // Last stop-bit cycle

   always_ff @(posedge clk) begin
      if (start_tx) begin
         byte_q <= tx_byte;
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state   <= TX_IDLE;
         tx_pin  <= 1'b1;
         bit_idx <= '0;
      end else begin
         case (state)
            TX_IDLE: begin
               if (start_tx) begin
                  state  <= TX_START;
                  tx_pin <= 1'b0;
               end
            end
            TX_START: begin
               if (bit_tick) begin
                  state   <= TX_DATA;
                  bit_idx <= '0;
                  tx_pin  <= byte_q[0];
               end
            end
            TX_DATA: begin
               if (bit_tick) begin
                  if (bit_idx == 3'd7) begin
                     state  <= TX_STOP;
                     tx_pin <= 1'b1;
                  end else begin
                     bit_idx <= bit_idx + 3'd1;
                     tx_pin  <= byte_q[bit_idx + 3'd1]; // LSB first
                  end
               end
            end
            TX_STOP: begin
               if (bit_tick) begin
                  if (start_tx) begin
                     state  <= TX_START; // Back to back without an idle gap
                     tx_pin <= 1'b0;
                  end else begin
                     state <= TX_IDLE;
                  end
               end
            end
            default: begin
               state  <= TX_IDLE;
               tx_pin <= 1'b1;
            end
         endcase
      end
   end

endmodule

`default_nettype wire

//--- baud_timer.sv
`timescale 1ns/1ps
`default_nettype none

module baud_timer import uart_pkg::*; (
   input  logic clk,
   input  logic arst_n,
   input  logic run,
   output logic half_tick,
   output logic bit_tick
);

   baud_count_t count;
   logic        at_half;
   logic        at_end;

   assign at_half = (count == baud_count_t'(HALF_DIV - 1));
   assign at_end  = (count == baud_count_t'(BAUD_DIV - 1));

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         count <= '0;
      end else begin
         if (!run) begin
            count <= '0; // Restart for the next frame
         end else if (at_end) begin
            count <= '0;
         end else begin
            count <= count + baud_count_t'(1);
         end
      end
   end

   // Ticks only while a frame is running
   assign half_tick = run && at_half;
   assign bit_tick  = run && at_end;

endmodule

`default_nettype wire

//--- uart_pkg.sv
`default_nettype none

package uart_pkg;

   localparam int BAUD_DIV = 16; // Clock cycles per bit
   localparam int HALF_DIV = BAUD_DIV / 2; // Mid-bit point

   typedef logic [7:0]  uart_byte_t; // Character on the line
   typedef logic [15:0] baud_count_t; // Position within one bit period
   typedef logic [31:0] bus_word_t; // Register bus word

   typedef enum logic [1:0] {
      TX_IDLE,
      TX_START,
      TX_DATA,
      TX_STOP
   } tx_state_t;

   typedef enum logic [1:0] {
      RX_IDLE,
      RX_START,
      RX_DATA,
      RX_STOP
   } rx_state_t;

   // Receiver report with single-cycle done and frame_err pulses
   typedef struct packed {
      uart_byte_t data;
      logic       done;
      logic       frame_err;
   } rx_event_t;

   typedef struct packed {
      logic rx_err; // Bit 4
      logic rxc; // Bit 3
      logic rx_en; // Bit 2
      logic tx_ready; // Bit 1
      logic txc; // Bit 0
   } uart_status_t;

endpackage

`default_nettype wire
